/* board_eval_testdata.txt */
# columns: test name, board in hex (square 63 first, one digit per square), expected mg, expected eg
# rows run from row 7 down to row 0, each row from column 7 down to column 0
start_position cabedbac99999999000000000000000000000000000000001111111142365324 0 0
open_file_white 000e000000000000000000000000000000000000000000000000000000060004 512 532
open_file_black c00e000000000000000000000000000000000000000000000000000000060000 -512 -532
half_open_white 0e0000000000900000000000000000000000000000000000000000000600400 0 405 428
own_pawn_white 0e000000000000000000000000000000000000000000000000001000 06004000 559 606
half_open_black 000e000c000000000000000000000000000000000000000000000001 00060000 -405 -428
material_uneven 000e0b00099000000000000000000000000000000000000000000000 00065020 833 732
mixed_rooks c00e0c00000000000000000000000000000000000000000010000000 00060404 107 104
doubled_rooks 000e0000000000000000000000000000000000000000000000000004 00060004 1024 1064
kings_only 000e000000000000000000000000000000000000000000000000000000060000 0 0
own_pawn_black 000ed00c000000090000000000000000000000000000000000000000 00060000 -1584 -1542

/* all.f */
chess_pkg.sv
eval_pkg.sv
eval_latency_sm.sv
eval_rook_files.sv
eval_material.sv
eval_combine.sv
board_eval_top.sv
board_eval_assertions.sv
tb_board_eval.sv

/* tb_board_eval.sv */
// board evaluator testbench.
// reads boards and expected totals from the data file and checks every result.
`timescale 1ns/1ns

module tb_board_eval;

   import chess_pkg::*;
   import eval_pkg::*;

   localparam int    clk_period   = 100;
   localparam int    reset_cycles = 8;
   localparam int    top_latency  = 6;    // board_valid cycle to eval_valid at the top.
   localparam int    wait_limit   = 20;
   localparam int    test_cycles  = 20;
   localparam string data_file    = "board_eval_testdata.txt";

   logic                   clk;
   logic                   rst_n;
   logic                   board_valid;
   logic [board_width-1:0] board;
   logic                   clear_eval;
   score_t                 eval_mg;
   score_t                 eval_eg;
   logic                   eval_valid;

   string                  test_name  [$];
   logic [board_width-1:0] test_board [$];
   score_t                 test_mg    [$];
   score_t                 test_eg    [$];

   int error_count  = 0;
   int tests_run    = 0;
   int tests_failed = 0;
   int cycle_count  = 0;
   int cycle_limit  = 0;

   board_eval_top #(
      .EVAL_WIDTH (eval_width)
   ) dut (
      .clk         (clk),
      .rst_n       (rst_n),
      .board_valid (board_valid),
      .board       (board),
      .clear_eval  (clear_eval),
      .eval_mg     (eval_mg),
      .eval_eg     (eval_eg),
      .eval_valid  (eval_valid)
   );

   initial
   begin
      clk = 1'b0;
      forever #(clk_period/2) clk = ~clk;
   end

   // ##################################################
   // test data and checks
   // ##################################################

   task automatic load_tests();
      int                     fd;
      int                     count;
      int                     mg;
      int                     eg;
      int                     start;
      byte                    ch;
      string                  line;
      string                  hex;
      string                  fields [$];
      logic [board_width-1:0] b;
      fd = $fopen(data_file, "r");
      if (fd == 0)
      begin
         $display("cannot open the test data file %s", data_file);
         error_count++;
      end
      else
      begin
         while (!$feof(fd))
         begin
            line = "";
            void'($fgets(line, fd));
            fields.delete();
            start = -1;
            for (int i = 0; i <= line.len(); i++)
            begin
               if (i < line.len())
                  ch = line.getc(i);
               else
                  ch = " ";
               if (ch == " " || ch == "\t" || ch == "\n" || ch == "\r")
               begin
                  if (start >= 0)
                     fields.push_back(line.substr(start, i - 1));
                  start = -1;
               end
               else if (start < 0)
                  start = i;
            end
            if (fields.size() > 0 && fields[0].getc(0) != "#")
            begin
               // the board may be split over several fields between name and scores.
               hex = "";
               for (int i = 1; i < fields.size() - 2; i++)
                  hex = {hex, fields[i]};
               count = 0;
               if (fields.size() >= 4 && hex.len() == board_squares)
               begin
                  count += $sscanf(hex, "%h", b);
                  count += $sscanf(fields[fields.size()-2], "%d", mg);
                  count += $sscanf(fields[fields.size()-1], "%d", eg);
               end
               if (count == 3)
               begin
                  test_name.push_back(fields[0]);
                  test_board.push_back(b);
                  test_mg.push_back(score_t'(mg));
                  test_eg.push_back(score_t'(eg));
               end
               else
               begin
                  $display("a test data line could not be read: %s", line);
                  error_count++;
               end
            end
         end
         $fclose(fd);
      end
      if (test_name.size() == 0)
      begin
         $display("no tests were found in the test data file");
         error_count++;
      end
   endtask

   task automatic compare_score(input string name, input score_t expected, input score_t actual);
      if (actual !== expected)
      begin
         $display("mismatch %s expected %0d actual %0d", name, expected, actual);
         error_count++;
      end
   endtask

   task automatic compare_valid(input string name, input logic expected, input logic actual);
      if (actual !== expected)
      begin
         $display("%s: eval_valid is %b when it should be %b", name, actual, expected);
         error_count++;
      end
   endtask

   task automatic compare_latency(input string name, input int expected, input int actual);
      if (actual != expected)
      begin
         $display("mismatch %s latency expected %0d actual %0d", name, expected, actual);
         error_count++;
      end
   endtask

   task automatic finish_test(input string name, input int errors_before);
      tests_run++;
      if (error_count == errors_before)
         $display("test %s passed", name);
      else
      begin
         tests_failed++;
         $display("test %s failed", name);
      end
   endtask

   // ##################################################
   // stimulus
   // ##################################################

   task automatic strobe_board(input logic [board_width-1:0] b);
      @(posedge clk);
      board       <= b;
      board_valid <= 1'b1;
   endtask

   task automatic end_strobe();
      @(posedge clk);
      board_valid <= 1'b0;
   endtask

   task automatic pulse_clear();
      @(posedge clk);
      clear_eval <= 1'b1;
      @(posedge clk);
      clear_eval <= 1'b0;
   endtask

   task automatic check_reset();
      int errors_before;
      errors_before = error_count;
      repeat (2) @(negedge clk);
      compare_valid("reset", 1'b0, eval_valid);
      finish_test("reset", errors_before);
   endtask

   // called on the edge that drops board_valid, one cycle after the last strobe.
   task automatic check_result(input string name, input score_t exp_mg, input score_t exp_eg);
      int waited;
      int errors_before;
      errors_before = error_count;
      waited        = 0;
      do
      begin
         @(negedge clk);
         waited++;
      end
      while (!eval_valid && waited < wait_limit);
      if (!eval_valid)
      begin
         $display("%s: eval_valid did not rise within %0d cycles", name, wait_limit);
         error_count++;
      end
      else
      begin
         compare_latency(name, top_latency, waited);
         compare_score({name, " mg"}, exp_mg, eval_mg);
         compare_score({name, " eg"}, exp_eg, eval_eg);
         @(negedge clk);
         compare_valid({name, " hold"}, 1'b1, eval_valid);   // holds until cleared.
      end
      pulse_clear();
      @(negedge clk);
      compare_valid({name, " clear"}, 1'b0, eval_valid);
      finish_test(name, errors_before);
   endtask

   initial
   begin
      int last;
      rst_n       = 1'b0;
      board_valid = 1'b0;
      board       = '0;
      clear_eval  = 1'b0;
      load_tests();
      cycle_limit = (test_name.size() + 2) * test_cycles + 50;
      repeat (reset_cycles) @(posedge clk);
      rst_n <= 1'b1;
      check_reset();
      for (int i = 0; i < test_name.size(); i++)
      begin
         strobe_board(test_board[i]);
         end_strobe();
         check_result(test_name[i], test_mg[i], test_eg[i]);
      end
      if (test_name.size() >= 2)
      begin
         // the second of two strobes on consecutive cycles wins.
         last = test_name.size() - 1;
         strobe_board(test_board[0]);
         strobe_board(test_board[last]);
         end_strobe();
         check_result("back_to_back", test_mg[last], test_eg[last]);
      end
      error_count += dut.u_assertions.failures;
      $display("tests run %0d, passed %0d, failed %0d, errors %0d",
               tests_run, tests_run - tests_failed, tests_failed, error_count);
      if (error_count == 0)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   end

   initial
   begin
      wait (cycle_limit > 0);
      while (cycle_count < cycle_limit)
      begin
         @(posedge clk);
         cycle_count++;
      end
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("CHECKS FAILED");
      $finish;
   end

endmodule

/* board_eval_assertions.sv */
// valid protocol checks for the board evaluator.
// bound into the top level, covering reset, latency and clear behaviour.
`timescale 1ns/1ns

module board_eval_assertions (
   input logic clk,
   input logic rst_n,
   input logic board_valid,
   input logic clear_eval,
   input logic eval_valid
);

   int unsigned failures = 0;

   // the first edge that samples reset clears the valid level.
   valid_low_in_reset: assert property (@(posedge clk) !rst_n |=> !eval_valid)
      else
      begin
         failures++;
         $error("eval_valid is high during reset");
      end

   // six cycles from strobe to valid when nothing intervenes.
   valid_after_strobe: assert property (@(posedge clk) disable iff (!rst_n)
         board_valid ##1 (!board_valid && !clear_eval) [*5] |=> eval_valid)
      else
      begin
         failures++;
         $error("eval_valid did not rise six cycles after board_valid");
      end

   quiet_after_strobe: assert property (@(posedge clk) disable iff (!rst_n)
         board_valid |-> ##2 (!eval_valid) [*4])   // no early result.
      else
      begin
         failures++;
         $error("eval_valid rose early after board_valid");
      end

   valid_falls_on_clear: assert property (@(posedge clk) disable iff (!rst_n)
         clear_eval |=> !eval_valid)
      else
      begin
         failures++;
         $error("eval_valid did not fall after clear_eval");
      end

   rise_needs_strobe: assert property (@(posedge clk) disable iff (!rst_n)
         $rose(eval_valid) |-> $past(board_valid, 6))
      else
      begin
         failures++;
         $error("eval_valid rose without a board_valid six cycles earlier");
      end

endmodule

bind board_eval_top board_eval_assertions u_assertions (
   .clk         (clk),
   .rst_n       (rst_n),
   .board_valid (board_valid),
   .clear_eval  (clear_eval),
   .eval_valid  (eval_valid)
);

/* board_eval_top.sv */
// board evaluator top level.
// runs both rook file evaluators and the material counter and combines their scores.
`timescale 1ns/1ns

module board_eval_top #(
   parameter int EVAL_WIDTH = eval_pkg::eval_width
) (
   input  logic                              clk,
   input  logic                              rst_n,
   input  logic                              board_valid,
   input  logic [chess_pkg::board_width-1:0] board,
   input  logic                              clear_eval,
   output eval_pkg::score_t                  eval_mg,
   output eval_pkg::score_t                  eval_eg,
   output logic                              eval_valid
);

   import eval_pkg::*;

   score_t white_mg, white_eg;
   score_t black_mg, black_eg;
   score_t material_mg, material_eg;
   logic   white_valid, black_valid, material_valid;

   eval_rook_files #(
      .EVAL_WIDTH  (EVAL_WIDTH),
      .WHITE_ROOKS (1'b1)
   ) u_rooks_white (
      .clk         (clk),
      .rst_n       (rst_n),
      .board_valid (board_valid),
      .board       (board),
      .clear_eval  (clear_eval),
      .eval_mg     (white_mg),
      .eval_eg     (white_eg),
      .eval_valid  (white_valid)
   );

   eval_rook_files #(
      .EVAL_WIDTH  (EVAL_WIDTH),
      .WHITE_ROOKS (1'b0)
   ) u_rooks_black (
      .clk         (clk),
      .rst_n       (rst_n),
      .board_valid (board_valid),
      .board       (board),
      .clear_eval  (clear_eval),
      .eval_mg     (black_mg),
      .eval_eg     (black_eg),
      .eval_valid  (black_valid)
   );

   eval_material #(
      .EVAL_WIDTH (EVAL_WIDTH)
   ) u_material (
      .clk         (clk),
      .rst_n       (rst_n),
      .board_valid (board_valid),
      .board       (board),
      .clear_eval  (clear_eval),
      .eval_mg     (material_mg),
      .eval_eg     (material_eg),
      .eval_valid  (material_valid)
   );

   eval_combine #(
      .EVAL_WIDTH (EVAL_WIDTH)
   ) u_combine (
      .clk            (clk),
      .rst_n          (rst_n),
      .clear_eval     (clear_eval),
      .white_mg       (white_mg),
      .white_eg       (white_eg),
      .white_valid    (white_valid),
      .black_mg       (black_mg),
      .black_eg       (black_eg),
      .black_valid    (black_valid),
      .material_mg    (material_mg),
      .material_eg    (material_eg),
      .material_valid (material_valid),
      .eval_mg        (eval_mg),
      .eval_eg        (eval_eg),
      .eval_valid     (eval_valid)
   );

endmodule

/* eval_combine.sv */
// score combiner.
// adds the three evaluator results into registered totals with a valid level.
`timescale 1ns/1ns

module eval_combine #(
   parameter int EVAL_WIDTH = eval_pkg::eval_width
) (
   input  logic             clk,
   input  logic             rst_n,
   input  logic             clear_eval,
   input  eval_pkg::score_t white_mg,
   input  eval_pkg::score_t white_eg,
   input  logic             white_valid,
   input  eval_pkg::score_t black_mg,
   input  eval_pkg::score_t black_eg,
   input  logic             black_valid,
   input  eval_pkg::score_t material_mg,
   input  eval_pkg::score_t material_eg,
   input  logic             material_valid,
   output eval_pkg::score_t eval_mg,
   output eval_pkg::score_t eval_eg,
   output logic             eval_valid
);

   import eval_pkg::*;

   logic signed [EVAL_WIDTH-1:0] sum_mg;
   logic signed [EVAL_WIDTH-1:0] sum_eg;

   assign sum_mg = EVAL_WIDTH'(white_mg) + EVAL_WIDTH'(black_mg) + EVAL_WIDTH'(material_mg);
   assign sum_eg = EVAL_WIDTH'(white_eg) + EVAL_WIDTH'(black_eg) + EVAL_WIDTH'(material_eg);

   // totals follow the evaluators every cycle. Only the valid level is qualified.
   always_ff @(posedge clk)
   begin
      eval_mg <= score_t'(sum_mg);
      eval_eg <= score_t'(sum_eg);
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
         eval_valid <= 1'b0;
      else if (clear_eval)
         eval_valid <= 1'b0;
      else
         eval_valid <= white_valid & black_valid & material_valid;
   end

endmodule

/* eval_material.sv */
// material counter.
// sums signed piece values of both colours in a five-stage pipeline.
`timescale 1ns/1ns

module eval_material #(
   parameter int EVAL_WIDTH = eval_pkg::eval_width
) (
   input  logic                              clk,
   input  logic                              rst_n,
   input  logic                              board_valid,
   input  logic [chess_pkg::board_width-1:0] board,
   input  logic                              clear_eval,
   output eval_pkg::score_t                  eval_mg,
   output eval_pkg::score_t                  eval_eg,
   output logic                              eval_valid
);

   import chess_pkg::*;
   import eval_pkg::*;

   logic signed [EVAL_WIDTH-1:0] value_mg_t1 [board_squares];
   logic signed [EVAL_WIDTH-1:0] value_eg_t1 [board_squares];
   logic signed [EVAL_WIDTH-1:0] row_sum_mg  [board_ranks];
   logic signed [EVAL_WIDTH-1:0] row_sum_eg  [board_ranks];
   logic signed [EVAL_WIDTH-1:0] row_mg_t2   [board_ranks];
   logic signed [EVAL_WIDTH-1:0] row_eg_t2   [board_ranks];
   logic signed [EVAL_WIDTH-1:0] total_sum_mg;
   logic signed [EVAL_WIDTH-1:0] total_sum_eg;
   logic signed [EVAL_WIDTH-1:0] total_mg_t3, total_eg_t3;
   logic signed [EVAL_WIDTH-1:0] total_mg_t4, total_eg_t4;

   // signed value of one square, negative for black pieces.
   function automatic score_t piece_value(input piece_t p, input logic endgame);
      score_t value;
      case (p)
         white_pawn,   black_pawn:   value = endgame ? pawn_eg   : pawn_mg;
         white_knight, black_knight: value = endgame ? knight_eg : knight_mg;
         white_bishop, black_bishop: value = endgame ? bishop_eg : bishop_mg;
         white_rook,   black_rook:   value = endgame ? rook_eg   : rook_mg;
         white_queen,  black_queen:  value = endgame ? queen_eg  : queen_mg;
         white_king,   black_king:   value = endgame ? king_eg   : king_mg;
         default:                    value = '0;
      endcase
      return (p >= black_pawn) ? -value : value;
   endfunction

   always_comb
   begin
      for (int row = 0; row < board_ranks; row++)
      begin
         row_sum_mg[row] = '0;
         row_sum_eg[row] = '0;
         for (int col = 0; col < board_files; col++)
         begin
            row_sum_mg[row] += value_mg_t1[row*board_files + col];
            row_sum_eg[row] += value_eg_t1[row*board_files + col];
         end
      end
      total_sum_mg = '0;
      total_sum_eg = '0;
      for (int row = 0; row < board_ranks; row++)
      begin
         total_sum_mg += row_mg_t2[row];
         total_sum_eg += row_eg_t2[row];
      end
   end

   always_ff @(posedge clk)
   begin
      for (int sq = 0; sq < board_squares; sq++)
      begin
         value_mg_t1[sq] <= EVAL_WIDTH'(piece_value(square_piece(board, sq), 1'b0));
         value_eg_t1[sq] <= EVAL_WIDTH'(piece_value(square_piece(board, sq), 1'b1));
      end
      row_mg_t2   <= row_sum_mg;
      row_eg_t2   <= row_sum_eg;
      total_mg_t3 <= total_sum_mg;
      total_eg_t3 <= total_sum_eg;
      total_mg_t4 <= total_mg_t3;   // pads the depth to match the rook pipelines.
      total_eg_t4 <= total_eg_t3;
      eval_mg     <= score_t'(total_mg_t4);
      eval_eg     <= score_t'(total_eg_t4);
   end

   eval_latency_sm #(
      .LATENCY_COUNT (eval_latency)
   ) u_latency (
      .clk         (clk),
      .rst_n       (rst_n),
      .board_valid (board_valid),
      .clear_eval  (clear_eval),
      .eval_valid  (eval_valid)
   );

endmodule

/* eval_rook_files.sv */
// rook open file evaluator.
// scores one colour's rooks on open and half-open files in a five-stage pipeline.
`timescale 1ns/1ns

module eval_rook_files #(
   parameter int EVAL_WIDTH  = eval_pkg::eval_width,
   parameter bit WHITE_ROOKS = 1'b1
) (
   input  logic                              clk,
   input  logic                              rst_n,
   input  logic                              board_valid,
   input  logic [chess_pkg::board_width-1:0] board,
   input  logic                              clear_eval,
   output eval_pkg::score_t                  eval_mg,
   output eval_pkg::score_t                  eval_eg,
   output logic                              eval_valid
);

   import chess_pkg::*;
   import eval_pkg::*;

   localparam piece_t my_rook       = WHITE_ROOKS ? white_rook : black_rook;
   localparam piece_t opponent_pawn = WHITE_ROOKS ? black_pawn : white_pawn;

   logic [board_width-1:0]       board_t1;
   logic [board_ranks-1:0]       open_mask_t1      [board_files];
   logic [board_ranks-1:0]       half_open_mask_t1 [board_files];
   logic [board_files-1:0]       file_open;
   logic [board_files-1:0]       file_half_open;
   logic signed [EVAL_WIDTH-1:0] bonus_mg_t2 [board_squares];
   logic signed [EVAL_WIDTH-1:0] bonus_eg_t2 [board_squares];
   logic signed [EVAL_WIDTH-1:0] row_sum_mg  [board_ranks];
   logic signed [EVAL_WIDTH-1:0] row_sum_eg  [board_ranks];
   logic signed [EVAL_WIDTH-1:0] row_mg_t3   [board_ranks];
   logic signed [EVAL_WIDTH-1:0] row_eg_t3   [board_ranks];
   logic signed [EVAL_WIDTH-1:0] total_sum_mg;
   logic signed [EVAL_WIDTH-1:0] total_sum_eg;
   logic signed [EVAL_WIDTH-1:0] total_mg_t4;
   logic signed [EVAL_WIDTH-1:0] total_eg_t4;

   // ##################################################
   // stage 1: per-file masks, one bit per row
   // ##################################################

   always_ff @(posedge clk)
   begin
      board_t1 <= board;   // the rook scan in stage 2 needs the same board.
      for (int col = 0; col < board_files; col++)
      begin
         for (int row = 0; row < board_ranks; row++)
         begin
            open_mask_t1[col][row] <=
               square_piece(board, row*board_files + col) inside {my_rook, empty};
            half_open_mask_t1[col][row] <=
               square_piece(board, row*board_files + col) inside {my_rook, empty, opponent_pawn};
         end
      end
   end

   always_comb
   begin
      for (int col = 0; col < board_files; col++)
      begin
         file_open[col]      = &open_mask_t1[col];
         file_half_open[col] = &half_open_mask_t1[col] & ~file_open[col];
      end
   end

   // ##################################################
   // stage 2: bonus for each own rook
   // ##################################################

   always_ff @(posedge clk)
   begin
      for (int sq = 0; sq < board_squares; sq++)
      begin
         if (square_piece(board_t1, sq) == my_rook && file_open[sq % board_files])
         begin
            bonus_mg_t2[sq] <= EVAL_WIDTH'(open_file_mg);
            bonus_eg_t2[sq] <= EVAL_WIDTH'(open_file_eg);
         end
         else if (square_piece(board_t1, sq) == my_rook && file_half_open[sq % board_files])
         begin
            bonus_mg_t2[sq] <= EVAL_WIDTH'(half_open_mg);
            bonus_eg_t2[sq] <= EVAL_WIDTH'(half_open_eg);
         end
         else
         begin
            bonus_mg_t2[sq] <= '0;
            bonus_eg_t2[sq] <= '0;
         end
      end
   end

   // ##################################################
   // stages 3 to 5: row sums, total, colour sign
   // ##################################################

   always_comb
   begin
      for (int row = 0; row < board_ranks; row++)
      begin
         row_sum_mg[row] = '0;
         row_sum_eg[row] = '0;
         for (int col = 0; col < board_files; col++)
         begin
            row_sum_mg[row] += bonus_mg_t2[row*board_files + col];
            row_sum_eg[row] += bonus_eg_t2[row*board_files + col];
         end
      end
   end

   always_comb
   begin
      total_sum_mg = '0;
      total_sum_eg = '0;
      for (int row = 0; row < board_ranks; row++)
      begin
         total_sum_mg += row_mg_t3[row];
         total_sum_eg += row_eg_t3[row];
      end
   end

   always_ff @(posedge clk)
   begin
      row_mg_t3   <= row_sum_mg;
      row_eg_t3   <= row_sum_eg;
      total_mg_t4 <= total_sum_mg;
      total_eg_t4 <= total_sum_eg;
      if (WHITE_ROOKS)
      begin
         eval_mg <= score_t'(total_mg_t4);
         eval_eg <= score_t'(total_eg_t4);
      end
      else
      begin
         eval_mg <= score_t'(-total_mg_t4);   // black scores count against white.
         eval_eg <= score_t'(-total_eg_t4);
      end
   end

   eval_latency_sm #(
      .LATENCY_COUNT (eval_latency)
   ) u_latency (
      .clk         (clk),
      .rst_n       (rst_n),
      .board_valid (board_valid),
      .clear_eval  (clear_eval),
      .eval_valid  (eval_valid)
   );

endmodule

/* eval_latency_sm.sv */
// evaluator result timing.
// counts the pipeline depth after board_valid and holds eval_valid until clear_eval.
`timescale 1ns/1ns

module eval_latency_sm #(
   parameter int LATENCY_COUNT = 5
) (
   input  logic clk,
   input  logic rst_n,
   input  logic board_valid,
   input  logic clear_eval,
   output logic eval_valid
);

   localparam int count_width = $clog2(LATENCY_COUNT);

   typedef enum logic [1:0] {
      st_idle,
      st_counting,
      st_done
   } state_t;

   state_t                 state;
   logic [count_width-1:0] count;

   // the load cycle and the final transition each take one edge of the count.
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state <= st_idle;
         count <= '0;
      end
      else if (board_valid)
      begin
         state <= st_counting;   // the newest strobe restarts the count.
         count <= count_width'(LATENCY_COUNT - 2);
      end
      else if (clear_eval)
         state <= st_idle;
      else
      begin
         case (state)
            st_counting:
            begin
               if (count == '0)
                  state <= st_done;
               else
                  count <= count - 1'b1;
            end
            default:
               state <= state;   // idle and done wait for a strobe or a clear.
         endcase
      end
   end

   assign eval_valid = (state == st_done);

endmodule

/* eval_pkg.sv */
// evaluation constants.
// score type, rook file bonuses, material values and pipeline depth.
package eval_pkg;

   localparam int eval_width   = 16;
   localparam int eval_latency = 5;   // cycles from board_valid to eval_valid.

   typedef logic signed [eval_width-1:0] score_t;

   // ##################################################
   // rook file bonuses
   // ##################################################

   localparam score_t open_file_mg = 16'sd35;
   localparam score_t open_file_eg = 16'sd20;
   localparam score_t half_open_mg = 16'sd10;
   localparam score_t half_open_eg = 16'sd10;

   // ##################################################
   // material values
   // ##################################################

   localparam score_t pawn_mg   = 16'sd82;
   localparam score_t pawn_eg   = 16'sd94;
   localparam score_t knight_mg = 16'sd337;
   localparam score_t knight_eg = 16'sd281;
   localparam score_t bishop_mg = 16'sd365;
   localparam score_t bishop_eg = 16'sd297;
   localparam score_t rook_mg   = 16'sd477;
   localparam score_t rook_eg   = 16'sd512;
   localparam score_t queen_mg  = 16'sd1025;
   localparam score_t queen_eg  = 16'sd936;
   localparam score_t king_mg   = 16'sd0;
   localparam score_t king_eg   = 16'sd0;

endpackage

/* chess_pkg.sv */
// chess board definitions.
// piece codes, board geometry and square decoding shared by the evaluators.
package chess_pkg;

   // square contents; bit 3 marks a black piece.
   typedef enum logic [3:0] {
      empty        = 4'd0,
      white_pawn   = 4'd1,
      white_knight = 4'd2,
      white_bishop = 4'd3,
      white_rook   = 4'd4,
      white_queen  = 4'd5,
      white_king   = 4'd6,
      black_pawn   = 4'd9,
      black_knight = 4'd10,
      black_bishop = 4'd11,
      black_rook   = 4'd12,
      black_queen  = 4'd13,
      black_king   = 4'd14
   } piece_t;

   // ##################################################
   // board geometry
   // ##################################################

   localparam int piece_width   = 4;
   localparam int board_files   = 8;
   localparam int board_ranks   = 8;
   localparam int board_squares = board_files * board_ranks;
   localparam int board_width   = board_squares * piece_width;   // 256 bits.

   // square index is row * 8 + column, row 0 being white's back rank.
   function automatic piece_t square_piece(input logic [board_width-1:0] board,
                                           input int unsigned sq);
      return piece_t'(board[sq*piece_width +: piece_width]);
   endfunction

endpackage
